//--- design/arcade_map_pkg.sv
// ----------------------------------------------------------------------
// CPU-side memory map of the work RAM window and its special cells.
// Offsets are relative to ram_base; only one 4K window is decoded.
// ----------------------------------------------------------------------
package arcade_map_pkg;

  // work RAM window seen by the CPU, 0x4800 to 0x57FF
  localparam logic [15:0] ram_base = 16'h4800;
  localparam int ram_addr_w = 12;
  localparam int ram_depth = 1 << ram_addr_w;

  // input port cells, CPU sees them at 0x5000 and 0x5040
  localparam logic [ram_addr_w-1:0] in0_offset = 12'h800;
  localparam logic [ram_addr_w-1:0] in1_offset = 12'h840;

  // game mode and credit cells
  localparam logic [ram_addr_w-1:0] mode_offset = 12'h600;
  localparam logic [ram_addr_w-1:0] credit_offset = 12'h66E;

  // interrupt enable register
  // a write here sets the enable from data bit 0, RAM is not touched
  localparam logic [15:0] int_en_addr = 16'h5000;

  // preset byte values written at power-up
  // all stick and coin bits inactive high
  localparam logic [7:0] in0_idle = 8'h9F;
  localparam logic [7:0] in1_idle = 8'hFF;
  // credit count loaded at boot
  localparam logic [7:0] credit_init = 8'h63;

  // upper nibble of an injected joystick byte
  localparam logic [3:0] move_prefix = 4'h9;

endpackage

//--- design/arcade_ctrl_pkg.sv
// ----------------------------------------------------------------------
// Bus request structs plus boot and frame interrupt timing constants.
// Interrupt period is scaled down for simulation.
// ----------------------------------------------------------------------
package arcade_ctrl_pkg;

  // CPU side request, strobes active low
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  dout;
    logic        mreq_n;
    logic        rd_n;
    logic        wr_n;
  } cpu_bus_t;

  // work RAM port request, strobes active high
  typedef struct packed {
    logic [arcade_map_pkg::ram_addr_w-1:0] addr;
    logic [7:0]                            din;
    logic                                  en;
    logic                                  we;
  } ram_req_t;

  // startup counter, stops at boot_done_count
  localparam int unsigned boot_done_count = 100;
  localparam int boot_cnt_w = $clog2(boot_done_count + 1);

  // preset write slots on the startup count
  localparam logic [boot_cnt_w-1:0] preset_in0_slot = 7'd10;
  localparam logic [boot_cnt_w-1:0] preset_in1_slot = 7'd20;
  localparam logic [boot_cnt_w-1:0] preset_mode_slot = 7'd30;
  localparam logic [boot_cnt_w-1:0] preset_credit_slot = 7'd40;

  // joystick change window, counter saturates one past it
  localparam int unsigned change_window = 20;
  localparam int change_cnt_w = $clog2(change_window + 2);

  // move byte slots on the change count
  localparam logic [change_cnt_w-1:0] move_in0_slot = 5'd5;
  localparam logic [change_cnt_w-1:0] move_in1_slot = 5'd10;

  // frame interrupt period in clock cycles
  localparam int unsigned int_period_cycles = 2000;
  localparam int int_cnt_w = $clog2(int_period_cycles + 1);

endpackage

//--- design/work_ram.sv
// ----------------------------------------------------------------------
// 4K x 8 single-port work RAM, write-first, read data registered.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module work_ram
  import arcade_map_pkg::*;
  import arcade_ctrl_pkg::*;
(
  input  logic       clk,
  input  ram_req_t   ram_req,
  output logic [7:0] rdata
);

  logic [7:0] mem [ram_depth];

  // write data shows on rdata in the same cycle as the store
  always_ff @(posedge clk) begin
    if (ram_req.en) begin
      if (ram_req.we) begin
        mem[ram_req.addr] <= ram_req.din;
        rdata             <= ram_req.din;
      end else begin
        rdata <= mem[ram_req.addr];
      end
    end
  end

endmodule

//--- design/frame_int_timer.sv
// ----------------------------------------------------------------------
// Free-running frame timer, int_n pulses low one cycle per wrap if enabled.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module frame_int_timer
  import arcade_ctrl_pkg::*;
(
  input  logic clk,
  input  logic reset_n,
  input  logic int_en_wr,
  input  logic int_en_bit,
  output logic cpu_int_n
);

  logic [int_cnt_w-1:0] int_cnt;
  logic                 int_en;
  logic                 wrap;

  // wrap after int_period_cycles, so pulses are period+1 apart
  assign wrap = (int_cnt == int_cnt_w'(int_period_cycles));

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      int_cnt   <= '0;
      cpu_int_n <= 1'b1;
    end else if (wrap) begin
      int_cnt   <= '0;
      cpu_int_n <= !int_en;
    end else begin
      int_cnt   <= int_cnt + 1'b1;
      cpu_int_n <= 1'b1;
    end
  end

  // enable taken from the 0x5000 write strobe
  // visible the cycle after the write
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      int_en <= 1'b0;
    end else if (int_en_wr) begin
      int_en <= int_en_bit;
    end
  end

endmodule

//--- design/ram_preset_writer.sv
// ----------------------------------------------------------------------
// Power-up preset writes and joystick byte injection into the input cells.
// ready stays low during boot and during every joystick change window.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module ram_preset_writer
  import arcade_map_pkg::*;
  import arcade_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic [1:0] sw_mode,
  input  logic [1:0] joystick,
  output ram_req_t   preset_req,
  output logic       ready
);

  logic [boot_cnt_w-1:0]   boot_cnt;
  logic [change_cnt_w-1:0] change_cnt;
  logic [1:0]              joy_q;
  logic                    boot_done;
  logic                    joy_change;
  logic [7:0]              move_byte;

  // low nibble of the input byte, one active-low bit per direction
  function automatic logic [3:0] move_code(input logic [1:0] joy);
    logic [3:0] code;
    case (joy)
      2'b00:   code = 4'hE;
      2'b01:   code = 4'hD;
      2'b10:   code = 4'hB;
      default: code = 4'h7;
    endcase
    return code;
  endfunction

  assign boot_done  = (boot_cnt == boot_cnt_w'(boot_done_count));
  assign joy_change = (joystick != joy_q);
  assign move_byte  = {move_prefix, move_code(joystick)};

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      boot_cnt   <= '0;
      change_cnt <= '0;
      joy_q      <= '0;
      ready      <= 1'b0;
    end else begin
      joy_q <= joystick;
      // startup count, holds once boot is done
      if (!boot_done) begin
        boot_cnt <= boot_cnt + 1'b1;
      end else if (change_cnt <= change_cnt_w'(change_window)) begin
        change_cnt <= change_cnt + 1'b1;
      end
      // stick moved, restart the injection window
      if (joy_change) begin
        change_cnt <= '0;
      end
      ready <= boot_done && (change_cnt > change_cnt_w'(change_window)) && !joy_change;
    end
  end

  // one-cycle write requests, only while the CPU is held off
  always_comb begin
    preset_req = '0;
    if (!ready) begin
      case (boot_cnt)
        preset_in0_slot: begin
          preset_req.addr = in0_offset;
          preset_req.din  = in0_idle;
          preset_req.en   = 1'b1;
          preset_req.we   = 1'b1;
        end
        preset_in1_slot: begin
          preset_req.addr = in1_offset;
          preset_req.din  = in1_idle;
          preset_req.en   = 1'b1;
          preset_req.we   = 1'b1;
        end
        preset_mode_slot: begin
          preset_req.addr = mode_offset;
          preset_req.din  = {6'd0, sw_mode};
          preset_req.en   = 1'b1;
          preset_req.we   = 1'b1;
        end
        preset_credit_slot: begin
          preset_req.addr = credit_offset;
          preset_req.din  = credit_init;
          preset_req.en   = 1'b1;
          preset_req.we   = 1'b1;
        end
        default: ;
      endcase
      // change count sits at zero until boot is done
      case (change_cnt)
        move_in0_slot: begin
          preset_req.addr = in0_offset;
          preset_req.din  = move_byte;
          preset_req.en   = 1'b1;
          preset_req.we   = 1'b1;
        end
        move_in1_slot: begin
          preset_req.addr = in1_offset;
          preset_req.din  = move_byte;
          preset_req.en   = 1'b1;
          preset_req.we   = 1'b1;
        end
        default: ;
      endcase
    end
  end

endmodule

//--- design/work_ram_arbiter.sv
// ----------------------------------------------------------------------
// Work RAM port mux between preset writer and CPU, plus the 0x5000 decode.
// CPU requests while wait_n is low are dropped, no retry.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module work_ram_arbiter
  import arcade_map_pkg::*;
  import arcade_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  cpu_bus_t   cpu_bus,
  input  ram_req_t   preset_req,
  input  logic       ready,
  input  logic [7:0] rdata,
  output ram_req_t   ram_req,
  output logic       int_en_wr,
  output logic       int_en_bit,
  output logic [7:0] cpu_di,
  output logic       cpu_wait_n
);

  logic [15:0] cpu_off;
  logic        in_window;
  logic        cpu_rd;
  logic        cpu_wr;
  logic        int_en_hit;
  logic        rd_pend;
  logic        rd_hit;
  logic [7:0]  cpu_di_q;
  logic [7:0]  rd_data;

  // CPU only sees the bus once the preset writer lets go
  assign cpu_wait_n = ready;

  // offset into the window and range check
  assign cpu_off   = cpu_bus.addr - ram_base;
  assign in_window = (cpu_bus.addr >= ram_base) && (cpu_off[15:ram_addr_w] == '0);

  // single-cycle strobes, honoured only while not waiting
  assign cpu_rd = ready && !cpu_bus.mreq_n && !cpu_bus.rd_n;
  assign cpu_wr = ready && !cpu_bus.mreq_n && !cpu_bus.wr_n;

  // interrupt enable register write, kept out of RAM
  assign int_en_hit = (cpu_bus.addr == int_en_addr);
  assign int_en_wr  = cpu_wr && int_en_hit;
  assign int_en_bit = cpu_bus.dout[0];

  always_comb begin
    if (!ready) begin
      ram_req = preset_req;
    end else begin
      ram_req.addr = cpu_off[ram_addr_w-1:0];
      ram_req.din  = cpu_bus.dout;
      // reads of 0x5000 still go to the input cell
      ram_req.en   = in_window && (cpu_rd || (cpu_wr && !int_en_hit));
      ram_req.we   = in_window && cpu_wr && !int_en_hit;
    end
  end

  // read completes one cycle after the request
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rd_pend <= 1'b0;
      rd_hit  <= 1'b0;
    end else begin
      rd_pend <= cpu_rd;
      rd_hit  <= cpu_rd && in_window;
    end
  end

  // out-of-window reads return zero
  assign rd_data = rd_hit ? rdata : 8'h00;

  // hold last read data, rdata moves on later accesses
  always_ff @(posedge clk) begin
    if (rd_pend) begin
      cpu_di_q <= rd_data;
    end
  end

  assign cpu_di = rd_pend ? rd_data : cpu_di_q;

endmodule

//--- design/arcade_glue_top.sv
// ----------------------------------------------------------------------
// Bus glue between the CPU bus and work RAM, with preset and frame timer.
// No CPU, ROM or video here, the bus comes in as a struct port.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module arcade_glue_top
  import arcade_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  cpu_bus_t   cpu_bus,
  input  logic [1:0] sw_mode,
  input  logic [1:0] joystick,
  output logic [7:0] cpu_di,
  output logic       cpu_wait_n,
  output logic       cpu_int_n
);

  ram_req_t   preset_req;
  ram_req_t   ram_req;
  logic       ready;
  logic [7:0] rdata;
  logic       int_en_wr;
  logic       int_en_bit;

  // boot presets and joystick bytes
  ram_preset_writer i_preset (
    .clk        (clk),
    .reset_n    (reset_n),
    .sw_mode    (sw_mode),
    .joystick   (joystick),
    .preset_req (preset_req),
    .ready      (ready)
  );

  // port mux, 0x5000 decode and read return
  work_ram_arbiter i_arb (
    .clk        (clk),
    .reset_n    (reset_n),
    .cpu_bus    (cpu_bus),
    .preset_req (preset_req),
    .ready      (ready),
    .rdata      (rdata),
    .ram_req    (ram_req),
    .int_en_wr  (int_en_wr),
    .int_en_bit (int_en_bit),
    .cpu_di     (cpu_di),
    .cpu_wait_n (cpu_wait_n)
  );

  work_ram i_ram (
    .clk     (clk),
    .ram_req (ram_req),
    .rdata   (rdata)
  );

  // frame interrupt
  frame_int_timer i_timer (
    .clk        (clk),
    .reset_n    (reset_n),
    .int_en_wr  (int_en_wr),
    .int_en_bit (int_en_bit),
    .cpu_int_n  (cpu_int_n)
  );

endmodule

//--- dv/tb_arcade_glue.sv
// ----------------------------------------------------------------------
// Directed testbench that plays the CPU bus and the joystick.
// Interrupt spacing assumes the scaled period from arcade_ctrl_pkg.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_arcade_glue
  import arcade_map_pkg::*;
  import arcade_ctrl_pkg::*;
();

  // generous bound on the whole run
  localparam int unsigned watchdog_cycles = 12 * int_period_cycles + 2000;

  logic        clk;
  logic        reset_n;
  cpu_bus_t    cpu_bus;
  logic [1:0]  sw_mode;
  logic [1:0]  joystick;
  logic [7:0]  cpu_di;
  logic        cpu_wait_n;
  logic        cpu_int_n;
  logic [31:0] rng_state;
  int unsigned cycle_cnt = 0;

  arcade_glue_top i_dut (
    .clk        (clk),
    .reset_n    (reset_n),
    .cpu_bus    (cpu_bus),
    .sw_mode    (sw_mode),
    .joystick   (joystick),
    .cpu_di     (cpu_di),
    .cpu_wait_n (cpu_wait_n),
    .cpu_int_n  (cpu_int_n)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // cycle stamp for interrupt spacing
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // 0x9 prefix and one low bit per stick direction
  function automatic logic [7:0] expected_move_byte(input logic [1:0] joy);
    case (joy)
      2'b00:   return 8'h9E;
      2'b01:   return 8'h9D;
      2'b10:   return 8'h9B;
      default: return 8'h97;
    endcase
  endfunction

  // input ports, mode and credit cells
  function automatic bit is_preset_cell(input logic [15:0] addr);
    return (addr == 16'h5000) || (addr == 16'h5040) || (addr == 16'h4E00) ||
           (addr == 16'h4E6E);
  endfunction

  task automatic fail_and_stop(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_and_stop($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // inputs change 1 ns after the edge
  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_for_wait_n(input logic level, input int unsigned max_cycles,
                                 input string what);
    int unsigned n;
    n = 0;
    while (cpu_wait_n !== level) begin
      if (n == max_cycles) begin
        fail_and_stop($sformatf("timed out waiting for %s", what));
      end
      step_cycle();
      n++;
    end
  endtask

  task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
    wait_for_wait_n(1'b1, 200, "bus release before a write");
    cpu_bus.addr   = addr;
    cpu_bus.dout   = data;
    cpu_bus.mreq_n = 1'b0;
    cpu_bus.wr_n   = 1'b0;
    step_cycle();
    cpu_bus.mreq_n = 1'b1;
    cpu_bus.wr_n   = 1'b1;
  endtask

  // data is valid the cycle after the request
  task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data);
    wait_for_wait_n(1'b1, 200, "bus release before a read");
    cpu_bus.addr   = addr;
    cpu_bus.mreq_n = 1'b0;
    cpu_bus.rd_n   = 1'b0;
    step_cycle();
    cpu_bus.mreq_n = 1'b1;
    cpu_bus.rd_n   = 1'b1;
    data = cpu_di;
  endtask

  // returns the cycle stamp of a one-cycle low pulse
  task automatic wait_int_pulse(output int unsigned stamp);
    int unsigned n;
    n = 0;
    while (cpu_int_n !== 1'b0) begin
      if (n > int_period_cycles + 2) begin
        fail_and_stop("no frame interrupt pulse within one period");
      end
      step_cycle();
      n++;
    end
    stamp = cycle_cnt;
    step_cycle();
    check_value("cpu_int_n pulse width", 32'(cpu_int_n), 32'h1);
  endtask

  task automatic check_reset_state();
    int unsigned n;
    check_value("cpu_wait_n", 32'(cpu_wait_n), 32'h0);
    check_value("cpu_int_n", 32'(cpu_int_n), 32'h1);
    n = 0;
    while (cpu_wait_n !== 1'b1) begin
      if (n == 200) begin
        fail_and_stop("cpu_wait_n did not rise within 200 cycles of reset");
      end
      check_value("cpu_int_n", 32'(cpu_int_n), 32'h1);
      step_cycle();
      n++;
    end
  endtask

  task automatic check_boot_presets();
    logic [7:0] rd;
    cpu_read(16'h4E00, rd);
    check_value("cpu_di @0x4E00", 32'(rd), 32'h03);
    cpu_read(16'h4E6E, rd);
    check_value("cpu_di @0x4E6E", 32'(rd), 32'h63);
    cpu_read(16'h5000, rd);
    check_value("cpu_di @0x5000", 32'(rd), 32'h9E);
    cpu_read(16'h5040, rd);
    check_value("cpu_di @0x5040", 32'(rd), 32'h9E);
  endtask

  task automatic check_cpu_access();
    logic [15:0] addr_q[$];
    logic [7:0]  data_q[$];
    logic [15:0] addr;
    logic [7:0]  rd;
    bit          clash;
    // distinct window addresses clear of the preset cells
    while (addr_q.size() < 16) begin
      rng_state = xorshift32(rng_state);
      addr = ram_base + {4'h0, rng_state[19:8]};
      clash = is_preset_cell(addr);
      foreach (addr_q[i]) begin
        if (addr_q[i] == addr) begin
          clash = 1'b1;
        end
      end
      if (!clash) begin
        addr_q.push_back(addr);
        data_q.push_back(rng_state[7:0]);
        cpu_write(addr, rng_state[7:0]);
      end
    end
    foreach (addr_q[i]) begin
      cpu_read(addr_q[i], rd);
      check_value($sformatf("cpu_di @0x%0h", addr_q[i]), 32'(rd), 32'(data_q[i]));
    end
    cpu_read(16'h3000, rd);
    check_value("cpu_di @0x3000", 32'(rd), 32'h0);
    // a write moves RAM read data to a different byte but cpu_di must hold
    cpu_read(addr_q[0], rd);
    cpu_write(addr_q[1], ~data_q[0]);
    repeat (5) step_cycle();
    check_value("cpu_di held", 32'(cpu_di), 32'(data_q[0]));
  endtask

  task automatic check_joystick(input logic [1:0] joy);
    logic [7:0] rd;
    joystick = joy;
    wait_for_wait_n(1'b0, 10, "cpu_wait_n low after a joystick change");
    wait_for_wait_n(1'b1, 50, "cpu_wait_n high after the injection window");
    cpu_read(16'h5000, rd);
    check_value("cpu_di @0x5000", 32'(rd), 32'(expected_move_byte(joy)));
    cpu_read(16'h5040, rd);
    check_value("cpu_di @0x5040", 32'(rd), 32'(expected_move_byte(joy)));
  endtask

  task automatic check_interrupt();
    int unsigned t_first;
    int unsigned t_second;
    logic [7:0]  rd;
    cpu_write(int_en_addr, 8'h01);
    wait_int_pulse(t_first);
    wait_int_pulse(t_second);
    check_value("int pulse spacing", t_second - t_first, int_period_cycles + 1);
    // enable write must not have landed in the input cell
    cpu_read(int_en_addr, rd);
    check_value("cpu_di @0x5000", 32'(rd), 32'(expected_move_byte(2'b11)));
    cpu_write(int_en_addr, 8'h00);
    repeat (2 * (int_period_cycles + 1)) begin
      step_cycle();
      check_value("cpu_int_n", 32'(cpu_int_n), 32'h1);
    end
  endtask

  initial begin
    rng_state      = 32'd88;
    reset_n        = 1'b0;
    cpu_bus.addr   = '0;
    cpu_bus.dout   = '0;
    cpu_bus.mreq_n = 1'b1;
    cpu_bus.rd_n   = 1'b1;
    cpu_bus.wr_n   = 1'b1;
    sw_mode        = 2'b11;
    joystick       = 2'b00;
    repeat (8) @(posedge clk);
    #1;
    reset_n = 1'b1;
    check_reset_state();
    check_boot_presets();
    check_cpu_access();
    check_joystick(2'b10);
    check_joystick(2'b01);
    check_joystick(2'b11);
    check_interrupt();
    $display("ALL TESTS PASSED");
    $finish;
  end

  // hard stop if a test never completes
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    fail_and_stop("watchdog expired, the tests ran longer than expected");
  end

endmodule

//--- tb.f
design/arcade_map_pkg.sv
design/arcade_ctrl_pkg.sv
design/work_ram.sv
design/frame_int_timer.sv
design/ram_preset_writer.sv
design/work_ram_arbiter.sv
design/arcade_glue_top.sv
dv/tb_arcade_glue.sv

//--- run_sim.sh
#!/bin/sh
# build and run the arcade glue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_arcade_glue -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_arcade_glue > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
